//--- noc_consts.svh
`ifndef NOC_CONSTS_SVH
`define NOC_CONSTS_SVH

// output port sizing, shared by the package and the RTL

// number of output virtual channels
`define NOC_VC_NUM 4

// slots in each downstream VC buffer
`define NOC_VC_DEPTH 4

// flit payload bits
`define NOC_PAYLOAD_W 16

// congestion hint width, saturates at all ones
`define NOC_CONG_W 4

`endif

//--- src/noc_pkg.sv
`default_nettype none
`include "noc_consts.svh"

package noc_pkg;

    typedef logic [`NOC_VC_NUM-1:0] vc_onehot_t;             // one bit per VC
    typedef logic [$clog2(`NOC_VC_NUM)-1:0] vc_bin_t;        // binary VC index
    typedef logic [$clog2(`NOC_VC_DEPTH+1)-1:0] occ_t;       // 0..depth inclusive
    typedef occ_t [`NOC_VC_NUM-1:0] occ_array_t;             // all VC occupancies
    typedef logic [`NOC_CONG_W-1:0] congestion_t;            // saturating total
    typedef logic [`NOC_PAYLOAD_W-1:0] payload_t;

    // single-flit packet carries head and tail together
    typedef struct packed {
        logic     head;                                      // first flit of packet
        logic     tail;                                      // last flit of packet
        payload_t payload;
    } flit_t;

    typedef struct packed {
        vc_bin_t vc;                                         // output VC it left on
        flit_t   flit;
    } out_flit_t;

    typedef enum logic {
        LOCK_IDLE = 1'b0,                                    // next head picks fresh
        LOCK_HELD = 1'b1                                     // packet owns a VC
    } lock_state_t;

endpackage

`default_nettype wire

//--- src/vc_occupancy_tracker.sv
`timescale 1ns/1ps
`default_nettype none
`include "noc_consts.svh"

module vc_occupancy_tracker (
    input  wire                  clk,
    input  wire                  rst_i,
    input  wire                  send_i,          // flit accepted this cycle
    input  wire noc_pkg::vc_bin_t    send_vc_i,   // VC the flit goes to
    input  wire noc_pkg::vc_onehot_t credit_i,    // one slot back per set bit
    output noc_pkg::occ_array_t  occ_o,
    output noc_pkg::vc_onehot_t  full_o,
    output noc_pkg::congestion_t congestion_o
);

    // wide enough for NUM * DEPTH without wrap
    localparam int SUM_W = $bits(noc_pkg::occ_t) + $clog2(`NOC_VC_NUM);

    noc_pkg::occ_array_t  occ_q;                  // registered counts
    noc_pkg::occ_array_t  occ_d;                  // counts after this edge
    noc_pkg::vc_onehot_t  up;                     // send strobe per VC
    logic [SUM_W-1:0]     occ_sum;                // unsaturated total
    noc_pkg::congestion_t cong_d;

    always_comb begin
        up = '0;
        up[send_vc_i] = send_i;                   // demux send onto its VC
    end

    // send and credit on one VC cancel out
    always_comb begin
        for (int v = 0; v < `NOC_VC_NUM; v++) begin
            occ_d[v] = occ_q[v];
            if (up[v] && !credit_i[v]) begin
                occ_d[v] = occ_q[v] + noc_pkg::occ_t'(1);
            end else if (credit_i[v] && !up[v] && occ_q[v] != '0) begin
                occ_d[v] = occ_q[v] - noc_pkg::occ_t'(1);   // no wrap below zero
            end
        end
    end

    // total of next counts so congestion lines up with occ
    always_comb begin
        occ_sum = '0;
        for (int v = 0; v < `NOC_VC_NUM; v++) begin
            occ_sum = occ_sum + SUM_W'(occ_d[v]);
        end
    end

    assign cong_d = (occ_sum[SUM_W-1:`NOC_CONG_W] != '0) ? '1   // clamp high
                                                          : occ_sum[`NOC_CONG_W-1:0];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            occ_q        <= '0;
            congestion_o <= '0;
        end else begin
            occ_q        <= occ_d;
            congestion_o <= cong_d;
        end
    end

    always_comb begin
        for (int v = 0; v < `NOC_VC_NUM; v++) begin
            full_o[v] = (occ_q[v] == noc_pkg::occ_t'(`NOC_VC_DEPTH));   // no slot left
        end
    end

    assign occ_o = occ_q;

endmodule

`default_nettype wire

//--- src/min_vc_select.sv
`timescale 1ns/1ps
`default_nettype none
`include "noc_consts.svh"

module min_vc_select (
    input  wire noc_pkg::occ_array_t occ_i,     // per-VC occupancy
    input  wire noc_pkg::vc_onehot_t full_i,    // VCs that cannot take a flit
    output noc_pkg::vc_bin_t         min_vc_o,  // least occupied free VC
    output logic                     any_free_o
);

    localparam int BIN_W = $bits(noc_pkg::vc_bin_t);

    noc_pkg::vc_onehot_t is_min;                // every VC that ties for min
    noc_pkg::vc_onehot_t first_min;             // lowest index among them

    // pairwise compare, full VCs drop out on both sides
    always_comb begin
        for (int i = 0; i < `NOC_VC_NUM; i++) begin
            is_min[i] = !full_i[i];             // full VC never wins
            for (int j = 0; j < `NOC_VC_NUM; j++) begin
                if (j != i) begin
                    // a full rival cannot beat us
                    is_min[i] = is_min[i] & (full_i[j] | (occ_i[i] <= occ_i[j]));
                end
            end
        end
    end

    // priority pass keeps only the first set bit
    always_comb begin
        logic seen;
        seen = 1'b0;
        for (int i = 0; i < `NOC_VC_NUM; i++) begin
            first_min[i] = is_min[i] & ~seen;
            seen         = seen | is_min[i];
        end
    end

    // one-hot to binary, masked OR of each index
    always_comb begin
        min_vc_o = '0;
        for (int i = 0; i < `NOC_VC_NUM; i++) begin
            min_vc_o = min_vc_o | ({BIN_W{first_min[i]}} & noc_pkg::vc_bin_t'(i));
        end
    end

    assign any_free_o = ~&full_i;               // at least one slot somewhere

endmodule

`default_nettype wire

//--- src/packet_vc_lock.sv
`timescale 1ns/1ps
`default_nettype none

module packet_vc_lock (
    input  wire                      clk,
    input  wire                      rst_i,
    input  wire                      flit_valid_i,  // sender strobe
    input  wire noc_pkg::flit_t      flit_i,
    input  wire noc_pkg::vc_bin_t    min_vc_i,      // fresh pick for a head
    input  wire                      any_free_i,
    input  wire noc_pkg::vc_onehot_t full_i,
    output noc_pkg::vc_bin_t         target_vc_o,   // VC this flit goes to
    output logic                     can_send_o,
    output logic                     send_o         // accepted flit
);

    noc_pkg::lock_state_t state_q;
    noc_pkg::vc_bin_t     held_vc_q;                // VC owned by current packet
    logic                 locked;

    assign locked = (state_q == noc_pkg::LOCK_HELD);

    // body and tail follow the head's VC
    assign target_vc_o = locked ? held_vc_q : min_vc_i;

    // only the held VC matters once locked
    assign can_send_o = locked ? !full_i[held_vc_q] : any_free_i;
    assign send_o     = flit_valid_i & can_send_o;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q   <= noc_pkg::LOCK_IDLE;
            held_vc_q <= '0;
        end else if (send_o) begin
            case (state_q)
                noc_pkg::LOCK_IDLE: begin
                    // single-flit packet never locks
                    if (flit_i.head && !flit_i.tail) begin
                        state_q   <= noc_pkg::LOCK_HELD;
                        held_vc_q <= min_vc_i;     // capture the winner
                    end
                end
                noc_pkg::LOCK_HELD: begin
                    if (flit_i.tail) begin
                        state_q <= noc_pkg::LOCK_IDLE;   // release after tail
                    end
                end
                default: begin
                    state_q <= noc_pkg::LOCK_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/out_vc_select.sv
`timescale 1ns/1ps
`default_nettype none

module out_vc_select (
    input  wire                      clk,
    input  wire                      rst_i,
    input  wire                      flit_valid_i,  // only while can_send_o
    input  wire noc_pkg::flit_t      flit_i,
    input  wire noc_pkg::vc_onehot_t credit_i,      // downstream slot returns
    output logic                     can_send_o,
    output logic                     flit_valid_o,  // one cycle per flit
    output noc_pkg::out_flit_t       flit_o,
    output noc_pkg::congestion_t     congestion_o
);

    noc_pkg::occ_array_t occ;                       // tracker to selector
    noc_pkg::vc_onehot_t full;
    noc_pkg::vc_bin_t    min_vc;
    noc_pkg::vc_bin_t    target_vc;
    logic                any_free;
    logic                send;                      // accepted this cycle

    vc_occupancy_tracker u_tracker (
        .clk          (clk),
        .rst_i        (rst_i),
        .send_i       (send),
        .send_vc_i    (target_vc),
        .credit_i     (credit_i),
        .occ_o        (occ),
        .full_o       (full),
        .congestion_o (congestion_o)
    );

    min_vc_select u_min_sel (
        .occ_i      (occ),
        .full_i     (full),
        .min_vc_o   (min_vc),
        .any_free_o (any_free)
    );

    packet_vc_lock u_lock (
        .clk          (clk),
        .rst_i        (rst_i),
        .flit_valid_i (flit_valid_i),
        .flit_i       (flit_i),
        .min_vc_i     (min_vc),
        .any_free_i   (any_free),
        .full_i       (full),
        .target_vc_o  (target_vc),
        .can_send_o   (can_send_o),
        .send_o       (send)
    );

    always_ff @(posedge clk) begin
        if (rst_i) begin
            flit_valid_o <= 1'b0;
        end else begin
            flit_valid_o <= send;                   // low in idle cycles
        end
    end

    // flit plus its VC, held until the next accept
    always_ff @(posedge clk) begin
        if (send) begin
            flit_o.vc   <= target_vc;
            flit_o.flit <= flit_i;
        end
    end

endmodule

`default_nettype wire

//--- dv/out_vc_select_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "noc_consts.svh"

module out_vc_select_tb;

    localparam int NUM_CYCLES     = 2000;                 // stimulus cycles
    localparam int SAT_START      = 700;                  // credits withheld from here
    localparam int SAT_END        = 1000;
    localparam int TIMEOUT_CYCLES = NUM_CYCLES + 500;     // reset and drain fit well inside
    localparam int CONG_MAX       = (1 << `NOC_CONG_W) - 1;

    logic                 clk;
    logic                 rst_i;
    logic                 flit_valid_i;
    noc_pkg::flit_t       flit_i;
    noc_pkg::vc_onehot_t  credit_i;
    logic                 can_send_o;
    logic                 flit_valid_o;
    noc_pkg::out_flit_t   flit_o;
    noc_pkg::congestion_t congestion_o;

    // reference model state, always the state after the last edge
    int                   m_occ [`NOC_VC_NUM];
    logic                 m_locked;
    int                   m_held;
    logic                 exp_valid;
    noc_pkg::out_flit_t   exp_flit;
    noc_pkg::congestion_t exp_cong;

    logic [31:0]          lcg_state;
    int                   flits_left;                     // flits still owed by current packet
    int                   cycle_count;

    out_vc_select DUT (
        .clk          (clk),
        .rst_i        (rst_i),
        .flit_valid_i (flit_valid_i),
        .flit_i       (flit_i),
        .credit_i     (credit_i),
        .can_send_o   (can_send_o),
        .flit_valid_o (flit_valid_o),
        .flit_o       (flit_o),
        .congestion_o (congestion_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                            // 8 ns period
    end

    function automatic int unsigned next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {16'd0, lcg_state[31:16]};                 // upper bits are the better ones
    endfunction

    // least occupied VC with a free slot, lowest index wins a tie
    function automatic noc_pkg::vc_bin_t expected_vc(input int occ [`NOC_VC_NUM]);
        int best;
        best = -1;
        for (int v = 0; v < `NOC_VC_NUM; v++) begin
            if (occ[v] < `NOC_VC_DEPTH && (best < 0 || occ[v] < occ[best])) begin
                best = v;
            end
        end
        if (best < 0) begin
            best = 0;                                     // nothing free, value unused
        end
        return noc_pkg::vc_bin_t'(best);
    endfunction

    function automatic logic model_can_send();
        logic free;
        free = 1'b0;
        if (m_locked) begin
            return m_occ[m_held] < `NOC_VC_DEPTH;         // only the held VC counts
        end
        for (int v = 0; v < `NOC_VC_NUM; v++) begin
            free = free | (m_occ[v] < `NOC_VC_DEPTH);
        end
        return free;
    endfunction

    task automatic abort_run(input string why);
        $display(">>> FAIL");
        $fatal(1, "%s", why);
    endtask

    task automatic check_can_send(input logic got, input logic want);
        if (got !== want) begin
            $display("Fail at %0t: can_send_o got %b want %b", $time, got, want);
            abort_run("can_send_o mismatch");
        end
    endtask

    task automatic check_congestion(input noc_pkg::congestion_t got,
                                    input noc_pkg::congestion_t want);
        if (got !== want) begin
            $display("Fail at %0t: congestion_o got %0d want %0d", $time, got, want);
            abort_run("congestion_o mismatch");
        end
    endtask

    task automatic check_flit(input logic got_valid, input noc_pkg::out_flit_t got,
                              input logic want_valid, input noc_pkg::out_flit_t want);
        if (got_valid !== want_valid) begin
            $display("Fail at %0t: flit_valid_o got %b want %b", $time, got_valid, want_valid);
            abort_run("flit_valid_o mismatch");
        end else if (want_valid && got !== want) begin
            $display("Fail at %0t: flit got vc %0d h%b t%b %h want vc %0d h%b t%b %h",
                     $time, got.vc, got.flit.head, got.flit.tail, got.flit.payload,
                     want.vc, want.flit.head, want.flit.tail, want.flit.payload);
            abort_run("flit_o mismatch");
        end
    endtask

    // what the upcoming edge does with these inputs
    task automatic step_model(input logic valid, input noc_pkg::flit_t flit,
                              input noc_pkg::vc_onehot_t credit);
        logic accept;
        logic up;
        int   tvc;
        int   sum;
        accept = valid && model_can_send();
        tvc    = m_locked ? m_held : int'(expected_vc(m_occ));
        exp_valid = accept;
        if (accept) begin
            exp_flit.vc   = noc_pkg::vc_bin_t'(tvc);
            exp_flit.flit = flit;
            if (!m_locked && flit.head && !flit.tail) begin
                m_locked = 1'b1;                          // head of a longer packet
                m_held   = tvc;
            end else if (m_locked && flit.tail) begin
                m_locked = 1'b0;                          // tail frees the VC
            end
        end
        sum = 0;
        for (int v = 0; v < `NOC_VC_NUM; v++) begin
            up = accept && (tvc == v);
            if (up && !credit[v]) begin
                m_occ[v] = m_occ[v] + 1;
            end else if (credit[v] && !up && m_occ[v] > 0) begin
                m_occ[v] = m_occ[v] - 1;
            end
            sum = sum + m_occ[v];
        end
        exp_cong = noc_pkg::congestion_t'((sum > CONG_MAX) ? CONG_MAX : sum);
    endtask

    task automatic drive_cycle(input int cyc);
        logic           sat;
        logic           attempt;
        int             cdiv;
        noc_pkg::flit_t f;
        sat     = (cyc >= SAT_START) && (cyc < SAT_END);
        cdiv    = (cyc < SAT_START) ? 8 : 4;              // slow credits first, then faster
        attempt = ((next_rand() % 10) < 6) || (cyc == 0); // first cycle always sends
        flit_valid_i = 1'b0;
        credit_i     = '0;
        if (attempt && model_can_send()) begin
            f.head = (flits_left == 0);
            if (flits_left == 0) begin
                flits_left = sat ? 1 : 1 + int'(next_rand() % 4);
            end
            f.tail       = (flits_left == 1);
            f.payload    = noc_pkg::payload_t'(next_rand());
            flits_left   = flits_left - 1;
            flit_i       = f;
            flit_valid_i = 1'b1;
        end
        // single flits with no credits fill all VCs
        if (!(sat && flits_left == 0)) begin
            for (int v = 0; v < `NOC_VC_NUM; v++) begin
                if (m_occ[v] > 0 && (next_rand() % cdiv) == 0) begin
                    credit_i[v] = 1'b1;
                end
            end
        end
    endtask

    // compare mid-cycle, then advance the model
    initial begin
        wait (rst_i == 1'b0);
        forever begin
            @(negedge clk);
            check_can_send(can_send_o, model_can_send());
            check_congestion(congestion_o, exp_cong);
            check_flit(flit_valid_o, flit_o, exp_valid, exp_flit);
            step_model(flit_valid_i, flit_i, credit_i);
        end
    end

    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clk);
            cycle_count = cycle_count + 1;
            if (cycle_count >= TIMEOUT_CYCLES) begin
                $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
                abort_run("timeout");
            end
        end
    end

    initial begin
        rst_i        = 1'b1;
        flit_valid_i = 1'b0;
        flit_i       = '0;
        credit_i     = '0;
        lcg_state    = 32'd67;
        flits_left   = 0;
        m_locked     = 1'b0;                              // model starts in reset state
        m_held       = 0;
        exp_valid    = 1'b0;
        exp_flit     = '0;
        exp_cong     = '0;
        for (int v = 0; v < `NOC_VC_NUM; v++) begin
            m_occ[v] = 0;
        end
        repeat (2) @(posedge clk);
        #1;
        rst_i = 1'b0;
        for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            drive_cycle(cyc);
            @(posedge clk);
            #1;
        end
        flit_valid_i = 1'b0;                              // drain, last flit shows up
        credit_i     = '0;
        repeat (3) @(posedge clk);
        #1;
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- out_vc_select.f
+incdir+.
src/noc_pkg.sv
src/vc_occupancy_tracker.sv
src/min_vc_select.sv
src/packet_vc_lock.sv
src/out_vc_select.sv
dv/out_vc_select_tb.sv

//--- Makefile
TOP := out_vc_select_tb
SIM := obj_dir/V$(TOP)

.PHONY: all lint clean

all: $(SIM)
	./$(SIM)

$(SIM): out_vc_select.f noc_consts.svh $(wildcard src/*.sv) $(wildcard dv/*.sv)
	verilator --binary --timing --top-module $(TOP) -f out_vc_select.f

lint:
	verilator --lint-only -Wall +incdir+. --top-module out_vc_select \
		src/noc_pkg.sv src/vc_occupancy_tracker.sv src/min_vc_select.sv \
		src/packet_vc_lock.sv src/out_vc_select.sv

clean:
	rm -rf obj_dir
